// ==== src/hd_defines.svh ====
`ifndef HD_DEFINES_SVH
`define HD_DEFINES_SVH

// hypervector width in bits
`define HD_DIM 64

// number of hardware threads, picked round robin
`define HD_THREADS 4

// item memory address width
`define HD_ITEM_AW 6

// entries in each of the command and result queues
`define HD_QUEUE_DEPTH 4

// wishbone address map
`define HD_ADR_W 8
`define HD_ADR_CMD 8'h00
`define HD_ADR_CTRL 8'h01
`define HD_ADR_STATUS 8'h02
`define HD_ADR_RESULT 8'h03
// item window, low HD_ITEM_AW bits select the entry
`define HD_ADR_ITEM_BASE 8'h40

`endif

// ==== src/hd_pkg.sv ====
`include "hd_defines.svh"

package hd_pkg;

    // one hypervector
    typedef logic [`HD_DIM-1:0] hv_t;

    // 16-bit instruction word, msb first
    typedef struct packed {
        logic       need_addr;
        logic       permute;
        logic       op_a;
        logic       op_b;
        logic       move;
        logic       last;
        logic       sign_wb;
        logic [8:0] addr;
    } instr_t;

    typedef enum logic [1:0] {
        CMD_INSTR,
        CMD_ITEM_WRITE,
        CMD_RESTART
    } cmd_kind_t;

    // entry of the command queue
    typedef struct packed {
        cmd_kind_t              kind;
        instr_t                 instr;
        logic [`HD_ITEM_AW-1:0] item_addr;
        hv_t                    data;
    } cmd_t;

    typedef logic [$clog2(`HD_THREADS)-1:0] thread_id_t;

endpackage

// ==== src/hd_bus_pkg.sv ====
`include "hd_defines.svh"

package hd_bus_pkg;

    // master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`HD_ADR_W-1:0] adr;
        logic [`HD_DIM-1:0]   dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic               ack;
        logic [`HD_DIM-1:0] dat;
    } wb_rsp_t;

    // status word, zero extended on the bus
    typedef struct packed {
        logic [2:0] result_count;
        logic       last_seen;
        logic       result_valid;
    } status_t;

endpackage

// ==== src/hd_queue.sv ====
`timescale 1ns/100ps

module hd_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       push,
    input  payload_t                   push_data,
    output logic                       full,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // head shown without a pop
    assign pop_data = mem[rd_ptr];
    assign full     = count == CW'(DEPTH);
    assign empty    = count == '0;

endmodule

// ==== src/hd_cmd_decoder.sv ====
`timescale 1ns/100ps
`include "hd_defines.svh"

module hd_cmd_decoder (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  hd_bus_pkg::wb_req_t                  wb_req,
    output hd_bus_pkg::wb_rsp_t                  wb_rsp,
    output logic                                 cmd_push,
    output hd_pkg::cmd_t                         cmd_data,
    input  logic                                 cmd_full,
    output logic                                 res_pop,
    input  hd_pkg::hv_t                          res_data,
    input  logic                                 res_empty,
    input  logic [$clog2(`HD_QUEUE_DEPTH+1)-1:0] res_count,
    input  logic                                 last_seen
);

    localparam logic [`HD_ADR_W-1:0] ITEM_BASE = `HD_ADR_ITEM_BASE;

    logic                ack_q;
    logic                result_hit_q;
    hd_pkg::hv_t         rd_dat_q;
    logic                req_valid;
    logic                hit_cmd;
    logic                hit_ctrl;
    logic                hit_item;
    logic                hit_status;
    logic                hit_result;
    logic                cmd_write;
    logic                accept;
    hd_bus_pkg::status_t status;

    // new request only, not the one being acked this cycle
    assign req_valid  = wb_req.cyc & wb_req.stb & ~ack_q;
    assign hit_cmd    = wb_req.adr == `HD_ADR_CMD;
    assign hit_ctrl   = wb_req.adr == `HD_ADR_CTRL;
    assign hit_status = wb_req.adr == `HD_ADR_STATUS;
    assign hit_result = wb_req.adr == `HD_ADR_RESULT;
    assign hit_item   = wb_req.adr[`HD_ADR_W-1:`HD_ITEM_AW] == ITEM_BASE[`HD_ADR_W-1:`HD_ITEM_AW];
    assign cmd_write  = wb_req.we & (hit_cmd | hit_ctrl | hit_item);

    // back-pressure, no ack until the command queue has room
    assign accept   = req_valid & ~(cmd_write & cmd_full);
    assign cmd_push = accept & cmd_write;

    always_comb begin
        cmd_data.kind      = hit_item ? hd_pkg::CMD_ITEM_WRITE :
                             hit_ctrl ? hd_pkg::CMD_RESTART : hd_pkg::CMD_INSTR;
        cmd_data.instr     = hd_pkg::instr_t'(wb_req.dat[15:0]);
        cmd_data.item_addr = wb_req.adr[`HD_ITEM_AW-1:0];
        cmd_data.data      = wb_req.dat;
    end

    always_comb begin
        status.result_valid = ~res_empty;
        status.last_seen    = last_seen;
        status.result_count = res_count;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q        <= 1'b0;
            result_hit_q <= 1'b0;
        end else begin
            ack_q        <= accept;
            result_hit_q <= accept & ~wb_req.we & hit_result & ~res_empty;
        end
    end

    // status and other read data, captured with the request
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_dat_q <= (!wb_req.we && hit_status) ? hd_pkg::hv_t'(status) : '0;
        end
    end

    // only this side pops, so the head is unchanged until the ack cycle
    assign res_pop = ack_q & result_hit_q;

    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.dat = result_hit_q ? res_data : rd_dat_q;
    end

endmodule

// ==== src/hd_exec_unit.sv ====
`timescale 1ns/100ps
`include "hd_defines.svh"

module hd_exec_unit (
    input  logic         clk,
    input  logic         arst_n,
    output logic         cmd_pop,
    input  hd_pkg::cmd_t cmd_data,
    input  logic         cmd_empty,
    output logic         res_push,
    output hd_pkg::hv_t  res_data,
    input  logic         res_full,
    output logic         last_seen
);

    localparam int THREADS = `HD_THREADS;
    localparam int ITEMS   = 2 ** `HD_ITEM_AW;

    hd_pkg::hv_t            item_mem [ITEMS];
    hd_pkg::hv_t            item_q;
    hd_pkg::hv_t            reg_1 [THREADS];
    hd_pkg::hv_t            reg_2 [THREADS];
    hd_pkg::thread_id_t     thread_ptr;
    hd_pkg::thread_id_t     load_thread;
    logic                   load_pending;
    hd_pkg::instr_t         instr;
    logic [`HD_ITEM_AW-1:0] instr_addr;
    logic                   is_instr;
    logic                   op_wb_item;
    logic                   op_load;
    logic                   op_xor;
    logic                   op_store;
    logic                   op_move;
    logic                   op_last;
    logic                   mem_we;
    logic [`HD_ITEM_AW-1:0] mem_waddr;
    hd_pkg::hv_t            mem_wdata;

    assign instr      = cmd_data.instr;
    assign instr_addr = instr.addr[`HD_ITEM_AW-1:0];
    assign is_instr   = cmd_data.kind == hd_pkg::CMD_INSTR;

    // priority decode of the instruction bits
    always_comb begin
        op_wb_item = 1'b0;
        op_load    = 1'b0;
        op_xor     = 1'b0;
        op_store   = 1'b0;
        op_move    = 1'b0;
        op_last    = 1'b0;
        if (is_instr) begin
            if (instr.need_addr) begin
                op_wb_item = instr.op_b;
                op_load    = instr.op_a & ~instr.op_b;
            end else if (instr.op_a) begin
                op_xor = 1'b1;
            end else if (instr.op_b) begin
                op_store = 1'b1;
            end else if (instr.move) begin
                op_move = 1'b1;
            end else begin
                op_last = instr.last;
            end
        end
    end

    // hold while a load finishes or the result queue has no room
    assign cmd_pop  = ~cmd_empty & ~load_pending & ~(op_store & res_full);
    assign res_push = cmd_pop & op_store;
    assign res_data = reg_2[thread_ptr];

    // single write port, host item or thread write-back
    assign mem_we    = cmd_pop & (cmd_data.kind == hd_pkg::CMD_ITEM_WRITE | op_wb_item);
    assign mem_waddr = op_wb_item ? instr_addr : cmd_data.item_addr;
    assign mem_wdata = op_wb_item ? reg_2[thread_ptr] : cmd_data.data;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            item_mem[mem_waddr] <= mem_wdata;
        end
        if (cmd_pop && op_load) begin
            item_q <= item_mem[instr_addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            thread_ptr   <= '0;
            load_thread  <= '0;
            load_pending <= 1'b0;
            last_seen    <= 1'b0;
            for (int t = 0; t < THREADS; t++) begin
                reg_1[t] <= '0;
                reg_2[t] <= '0;
            end
        end else begin
            load_pending <= cmd_pop & op_load;
            // second load cycle, memory data into reg_2
            if (load_pending) begin
                reg_2[load_thread] <= item_q;
            end
            if (cmd_pop && cmd_data.kind == hd_pkg::CMD_RESTART) begin
                // item memory is left as it is
                thread_ptr <= '0;
                last_seen  <= 1'b0;
                for (int t = 0; t < THREADS; t++) begin
                    reg_1[t] <= '0;
                    reg_2[t] <= '0;
                end
            end else if (cmd_pop && is_instr) begin
                thread_ptr <= (thread_ptr == hd_pkg::thread_id_t'(THREADS - 1)) ?
                              '0 : thread_ptr + 1'b1;
                if (op_load) begin
                    load_thread <= thread_ptr;
                end
                if (op_xor) begin
                    reg_2[thread_ptr] <= reg_1[thread_ptr] ^ reg_2[thread_ptr];
                end
                if (op_move) begin
                    reg_1[thread_ptr] <= reg_2[thread_ptr];
                end
                if (op_last) begin
                    last_seen <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/hd_core_top.sv ====
`timescale 1ns/100ps
`include "hd_defines.svh"

module hd_core_top (
    input  logic                clk,
    input  logic                arst_n,
    input  hd_bus_pkg::wb_req_t wb_req,
    output hd_bus_pkg::wb_rsp_t wb_rsp
);

    localparam int CW = $clog2(`HD_QUEUE_DEPTH + 1);

    logic          cmd_push;
    logic          cmd_full;
    logic          cmd_pop;
    logic          cmd_empty;
    hd_pkg::cmd_t  cmd_push_data;
    hd_pkg::cmd_t  cmd_pop_data;
    logic          res_push;
    logic          res_full;
    logic          res_pop;
    logic          res_empty;
    hd_pkg::hv_t   res_push_data;
    hd_pkg::hv_t   res_pop_data;
    logic [CW-1:0] res_count;
    logic          last_seen;

    hd_cmd_decoder u_cmd_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .cmd_push  (cmd_push),
        .cmd_data  (cmd_push_data),
        .cmd_full  (cmd_full),
        .res_pop   (res_pop),
        .res_data  (res_pop_data),
        .res_empty (res_empty),
        .res_count (res_count),
        .last_seen (last_seen)
    );

    // bus commands toward the execution unit
    hd_queue #(.payload_t(hd_pkg::cmd_t), .DEPTH(`HD_QUEUE_DEPTH)) u_cmd_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (cmd_push),
        .push_data (cmd_push_data),
        .full      (cmd_full),
        .pop       (cmd_pop),
        .pop_data  (cmd_pop_data),
        .empty     (cmd_empty),
        .count     ()
    );

    // stored hypervectors back to the host
    hd_queue #(.payload_t(hd_pkg::hv_t), .DEPTH(`HD_QUEUE_DEPTH)) u_res_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (res_push),
        .push_data (res_push_data),
        .full      (res_full),
        .pop       (res_pop),
        .pop_data  (res_pop_data),
        .empty     (res_empty),
        .count     (res_count)
    );

    hd_exec_unit u_exec_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_pop   (cmd_pop),
        .cmd_data  (cmd_pop_data),
        .cmd_empty (cmd_empty),
        .res_push  (res_push),
        .res_data  (res_push_data),
        .res_full  (res_full),
        .last_seen (last_seen)
    );

endmodule

// ==== dv/hd_core_chk.sv ====
`timescale 1ns/100ps

module hd_core_chk (
    input logic                clk,
    input logic                arst_n,
    input hd_bus_pkg::wb_rsp_t wb_rsp,
    input logic                cmd_push,
    input logic                cmd_full,
    input logic                cmd_pop,
    input logic                cmd_empty,
    input logic                res_push,
    input logic                res_full,
    input logic                res_pop,
    input logic                res_empty
);

    // single-cycle ack per transfer
    ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack stayed high for two cycles");

    no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        !(cmd_push && cmd_full) && !(res_push && res_full))
        else $error("queue pushed while full");

    no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        !(cmd_pop && cmd_empty) && !(res_pop && res_empty))
        else $error("queue popped while empty");

endmodule

bind hd_core_top hd_core_chk i_hd_core_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_rsp    (wb_rsp),
    .cmd_push  (cmd_push),
    .cmd_full  (cmd_full),
    .cmd_pop   (cmd_pop),
    .cmd_empty (cmd_empty),
    .res_push  (res_push),
    .res_full  (res_full),
    .res_pop   (res_pop),
    .res_empty (res_empty)
);

// ==== dv/hd_core_tb.sv ====
`timescale 1ns/100ps
`include "hd_defines.svh"

module hd_core_tb;

    localparam int TIMEOUT = 200;

    // instruction words, bit positions as in instr_t
    localparam logic [15:0] OP_NOP   = 16'h0000;
    localparam logic [15:0] OP_LOAD  = 16'hA000;
    localparam logic [15:0] OP_WB    = 16'h9000;
    localparam logic [15:0] OP_XOR   = 16'h2000;
    localparam logic [15:0] OP_STORE = 16'h1000;
    localparam logic [15:0] OP_MOVE  = 16'h0800;
    localparam logic [15:0] OP_LAST  = 16'h0400;

    // status word fields
    localparam logic [4:0] ST_VALID = 5'b00001;
    localparam logic [4:0] ST_LAST  = 5'b00010;
    localparam logic [4:0] ST_COUNT = 5'b11100;

    logic                clk;
    logic                arst_n;
    hd_bus_pkg::wb_req_t wb_req;
    hd_bus_pkg::wb_rsp_t wb_rsp;

    // reference model
    hd_pkg::hv_t model_mem [2 ** `HD_ITEM_AW];
    hd_pkg::hv_t model_reg_1 [`HD_THREADS];
    hd_pkg::hv_t model_reg_2 [`HD_THREADS];
    hd_pkg::hv_t expected [$];
    int          instr_count;

    hd_core_top i_hd_core_top (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopping the run");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [`HD_ADR_W-1:0] adr,
                             input hd_pkg::hv_t wdat, output hd_pkg::hv_t rdat);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        // hold the request until ack shows up
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("bus cycle to address 0x%h was never acknowledged", adr);
                stop_run();
            end
        end while (!wb_rsp.ack);
        rdat       = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic poll_status(input logic [4:0] mask, input logic [4:0] want);
        hd_pkg::hv_t rd;
        int          polls;
        polls = 0;
        bus_cycle(1'b0, `HD_ADR_STATUS, '0, rd);
        while ((rd[4:0] & mask) != want) begin
            polls++;
            if (polls > TIMEOUT) begin
                $display("status never reached the awaited value, last read 0x%h", rd);
                stop_run();
            end
            bus_cycle(1'b0, `HD_ADR_STATUS, '0, rd);
        end
    endtask

    function automatic hd_pkg::hv_t rand_hv();
        return {$urandom(), $urandom()};
    endfunction

    // instruction rules, first match wins
    function automatic void model_instr(input logic [15:0] word);
        hd_pkg::instr_t         ins;
        logic [`HD_ITEM_AW-1:0] a;
        int                     t;
        ins = hd_pkg::instr_t'(word);
        a   = ins.addr[`HD_ITEM_AW-1:0];
        t   = instr_count % `HD_THREADS;
        if (ins.need_addr && ins.op_b) begin
            model_mem[a] = model_reg_2[t];
        end else if (ins.need_addr && ins.op_a) begin
            model_reg_2[t] = model_mem[a];
        end else if (ins.need_addr) begin
            // address without a data op, nothing changes
        end else if (ins.op_a) begin
            model_reg_2[t] = model_reg_1[t] ^ model_reg_2[t];
        end else if (ins.op_b) begin
            expected.push_back(model_reg_2[t]);
        end else if (ins.move) begin
            model_reg_1[t] = model_reg_2[t];
        end
        instr_count++;
    endfunction

    function automatic void model_restart();
        for (int t = 0; t < `HD_THREADS; t++) begin
            model_reg_1[t] = '0;
            model_reg_2[t] = '0;
        end
        instr_count = 0;
    endfunction

    task automatic send_instr(input logic [15:0] word);
        hd_pkg::hv_t rd;
        bus_cycle(1'b1, `HD_ADR_CMD, 64'(word), rd);
        model_instr(word);
    endtask

    task automatic write_item(input int a, input hd_pkg::hv_t data);
        hd_pkg::hv_t rd;
        bus_cycle(1'b1, `HD_ADR_ITEM_BASE | 8'(a), data, rd);
        model_mem[a] = data;
    endtask

    task automatic read_result_check(input string name);
        hd_pkg::hv_t rd;
        poll_status(ST_VALID, ST_VALID);
        bus_cycle(1'b0, `HD_ADR_RESULT, '0, rd);
        check_value(name, rd, expected.pop_front());
    endtask

    task automatic test_reset_state();
        hd_pkg::hv_t rd;
        bus_cycle(1'b0, `HD_ADR_STATUS, '0, rd);
        check_value("status", rd, '0);
        bus_cycle(1'b0, `HD_ADR_RESULT, '0, rd);
        check_value("result", rd, '0);
    endtask

    task automatic test_load_store();
        for (int a = 0; a < 16; a++) begin
            write_item(a, rand_hv());
        end
        // one load per thread, then one store per thread
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_LOAD | 16'(t * 3));
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_STORE);
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            read_result_check("load_store result");
        end
    endtask

    task automatic test_xor_move();
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_LOAD | 16'(t));
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_MOVE);
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_LOAD | 16'(8 + t));
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_XOR);
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_STORE);
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            read_result_check("xor_move result");
        end
    endtask

    task automatic test_wb_item();
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_LOAD | 16'(4 + t));
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_WB | 16'(32 + t));
        end
        // read back rotated, so each thread gets a neighbour's vector
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_LOAD | 16'(32 + (t + 1) % `HD_THREADS));
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            send_instr(OP_STORE);
        end
        for (int t = 0; t < `HD_THREADS; t++) begin
            read_result_check("wb_item result");
        end
    endtask

    task automatic test_back_pressure();
        hd_pkg::hv_t rd;
        for (int i = 0; i < 8; i++) begin
            send_instr(OP_STORE);
        end
        poll_status(ST_COUNT, 5'b10000);
        // stores beyond the queue depth must stay parked
        bus_cycle(1'b0, `HD_ADR_STATUS, '0, rd);
        check_value("result_count", 64'(rd[4:2]), 64'd4);
        for (int i = 0; i < 8; i++) begin
            read_result_check("back_pressure result");
        end
    endtask

    task automatic test_last_restart();
        hd_pkg::hv_t rd;
        send_instr(OP_LAST);
        poll_status(ST_LAST, ST_LAST);
        bus_cycle(1'b1, `HD_ADR_CTRL, '0, rd);
        model_restart();
        poll_status(ST_LAST, 5'b00000);
        send_instr(OP_STORE);
        read_result_check("store after restart");
        // item memory survives the restart
        send_instr(OP_LOAD | 16'd2);
        for (int i = 0; i < 3; i++) begin
            send_instr(OP_NOP);
        end
        send_instr(OP_STORE);
        read_result_check("item after restart");
    endtask

    initial begin
        void'($urandom(32'ha988f85f));
        wb_req = '0;
        arst_n = 1'b0;
        for (int a = 0; a < 2 ** `HD_ITEM_AW; a++) begin
            model_mem[a] = '0;
        end
        model_restart();
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_load_store();
        test_xor_move();
        test_wb_item();
        test_back_pressure();
        test_last_restart();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/hd_pkg.sv
src/hd_bus_pkg.sv
src/hd_queue.sv
src/hd_cmd_decoder.sv
src/hd_exec_unit.sv
src/hd_core_top.sv
dv/hd_core_chk.sv
dv/hd_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := hd_core_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
